// File: hw/dram_pkg.sv
/*
 * Shared widths for the DRAM user port.
 * Request queue entry layout widths.
 * Front-end and issuer state enums, application opcodes.
 */

package dram_pkg;

    // host side
    localparam int USER_ADDR_W = 32;
    localparam int USER_DATA_W = 32;
    localparam int USER_MASK_W = 4;

    // controller application side
    localparam int APP_ADDR_W = 28;
    localparam int APP_DATA_W = 128;
    localparam int APP_MASK_W = 16;

    // entry is {write flag, address, data, mask}
    localparam int REQ_ENTRY_W = 1 + USER_ADDR_W + USER_DATA_W + USER_MASK_W;

    localparam int QUEUE_DEPTH_LOG2 = 2;

    typedef enum logic [1:0] {
        FE_CALIB = 2'b00,
        FE_IDLE  = 2'b01,
        FE_WRITE = 2'b10,
        FE_READ  = 2'b11
    } frontend_state_e;

    typedef enum logic [1:0] {
        IS_IDLE      = 2'b00,
        IS_CMD_WDATA = 2'b01,
        IS_CMD       = 2'b10,
        IS_WDATA     = 2'b11
    } issuer_state_e;

    // opcodes as the controller expects them
    typedef enum logic [2:0] {
        CMD_WRITE = 3'b000,
        CMD_READ  = 3'b001
    } app_cmd_e;

endpackage

// File: hw/dram_req_queue.sv
/*
 * Synchronous show-ahead FIFO.
 * Register array with wrap-bit pointers and registered full/empty flags.
 */

`timescale 1ns/1ps

module dram_req_queue #(
    parameter int WIDTH      = 32,
    parameter int DEPTH_LOG2 = 2
) (
    input  logic             clk,
    input  logic             rst_x_async,
    input  logic             i_push,
    input  logic [WIDTH-1:0] i_data,
    input  logic             i_pop,
    output logic [WIDTH-1:0] o_data,
    output logic             o_empty,
    output logic             o_full
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [DEPTH_LOG2:0] wr_ptr;
    logic [DEPTH_LOG2:0] rd_ptr;
    logic [DEPTH_LOG2:0] wr_ptr_nxt;
    logic [DEPTH_LOG2:0] rd_ptr_nxt;
    logic                do_push;
    logic                do_pop;
    logic                empty_nxt;
    logic                full_nxt;

    // requests against the flags are dropped
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    assign wr_ptr_nxt = wr_ptr + {{DEPTH_LOG2{1'b0}}, do_push};
    assign rd_ptr_nxt = rd_ptr + {{DEPTH_LOG2{1'b0}}, do_pop};

    assign empty_nxt = (wr_ptr_nxt == rd_ptr_nxt);
    // same slot, opposite wrap
    assign full_nxt  = (wr_ptr_nxt[DEPTH_LOG2] != rd_ptr_nxt[DEPTH_LOG2]) &&
                       (wr_ptr_nxt[DEPTH_LOG2-1:0] == rd_ptr_nxt[DEPTH_LOG2-1:0]);

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_empty <= 1'b1;
            o_full  <= 1'b0;
        end else begin
            wr_ptr  <= wr_ptr_nxt;
            rd_ptr  <= rd_ptr_nxt;
            o_empty <= empty_nxt;
            o_full  <= full_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[DEPTH_LOG2-1:0]] <= i_data;
        end
    end

    // head entry, valid while not empty
    assign o_data = mem[rd_ptr[DEPTH_LOG2-1:0]];

endmodule

// File: hw/dram_req_frontend.sv
/*
 * Host-side request front end.
 * Calibration synchronizer, request FSM and busy flag,
 * request entry packing and read-line hold register.
 */

`timescale 1ns/1ps

module dram_req_frontend import dram_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_x_async,
    input  logic                   i_rd_en,
    input  logic                   i_wr_en,
    input  logic [USER_ADDR_W-1:0] i_addr,
    input  logic [USER_DATA_W-1:0] i_data,
    input  logic [USER_MASK_W-1:0] i_mask,
    input  logic                   i_init_calib_complete,
    input  logic                   i_req_full,
    input  logic                   i_rd_empty,
    input  logic [APP_DATA_W-1:0]  i_rd_line,
    output logic                   o_busy,
    output logic                   o_init_calib_complete,
    output logic                   o_req_push,
    output logic [REQ_ENTRY_W-1:0] o_req_entry,
    output logic                   o_rd_pop,
    output logic [APP_DATA_W-1:0]  o_data
);

    frontend_state_e state;
    logic            calib_sync1;
    logic            calib_sync2;
    logic            strobe;

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            calib_sync1 <= 1'b0;
            calib_sync2 <= 1'b0;
        end else begin
            calib_sync1 <= i_init_calib_complete;
            calib_sync2 <= calib_sync1;
        end
    end

    assign o_init_calib_complete = calib_sync2;

    // strobes only count in IDLE, write wins over read
    assign strobe     = (state == FE_IDLE) && (i_wr_en || i_rd_en);
    assign o_req_push = strobe;
    assign o_req_entry = {i_wr_en, i_addr, i_data, i_wr_en ? i_mask : {USER_MASK_W{1'b0}}};

    // leaving READ takes the returned line
    assign o_rd_pop = (state == FE_READ) && !i_rd_empty;

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            state <= FE_CALIB;
        end else begin
            case (state)
                FE_CALIB: begin
                    if (calib_sync2) begin
                        state <= FE_IDLE;
                    end
                end
                FE_IDLE: begin
                    if (i_wr_en) begin
                        state <= FE_WRITE;
                    end else if (i_rd_en) begin
                        state <= FE_READ;
                    end
                end
                FE_WRITE: begin
                    // stay busy while the controller holds the queue full
                    if (!i_req_full) begin
                        state <= FE_IDLE;
                    end
                end
                FE_READ: begin
                    if (!i_rd_empty) begin
                        state <= FE_IDLE;
                    end
                end
                default: begin
                    state <= FE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_rd_pop) begin
            o_data <= i_rd_line;
        end
    end

    assign o_busy = (state != FE_IDLE);

endmodule

// File: hw/dram_app_issuer.sv
/*
 * Application interface command issuer.
 * Pops queued requests, drives command and write-data channels,
 * places the user word and byte mask into the 128-bit line.
 */

`timescale 1ns/1ps

module dram_app_issuer import dram_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_x_async,
    input  logic                   i_req_empty,
    input  logic [REQ_ENTRY_W-1:0] i_req_entry,
    input  logic                   i_app_rdy,
    input  logic                   i_app_wdf_rdy,
    output logic                   o_req_pop,
    output logic                   o_app_en,
    output app_cmd_e               o_app_cmd,
    output logic [APP_ADDR_W-1:0]  o_app_addr,
    output logic [APP_DATA_W-1:0]  o_app_wdf_data,
    output logic                   o_app_wdf_wren,
    output logic                   o_app_wdf_end,
    output logic [APP_MASK_W-1:0]  o_app_wdf_mask
);

    issuer_state_e          state;
    logic                   ent_wr;
    logic [USER_ADDR_W-1:0] ent_addr;
    logic [USER_DATA_W-1:0] ent_data;
    logic [USER_MASK_W-1:0] ent_mask;
    logic [1:0]             lane;
    logic [APP_MASK_W-1:0]  line_mask;
    logic [APP_ADDR_W-1:0]  line_addr;
    logic                   done;
    logic                   take;

    assign {ent_wr, ent_addr, ent_data, ent_mask} = i_req_entry;

    assign lane = ent_addr[3:2];

    // 16-byte line address, low three bits stay zero
    assign line_addr = {1'b0, ent_addr[27:4], 3'b000};

    // mask bit set means the byte is not written
    always_comb begin
        for (int l = 0; l < 4; l++) begin
            if (lane == l[1:0]) begin
                line_mask[l*USER_MASK_W +: USER_MASK_W] = ent_mask;
            end else begin
                line_mask[l*USER_MASK_W +: USER_MASK_W] = {USER_MASK_W{1'b1}};
            end
        end
    end

    // every pending channel of the current request accepted
    always_comb begin
        case (state)
            IS_IDLE:      done = 1'b1;
            IS_CMD_WDATA: done = i_app_rdy && i_app_wdf_rdy;
            IS_CMD:       done = i_app_rdy;
            IS_WDATA:     done = i_app_wdf_rdy;
            default:      done = 1'b1;
        endcase
    end

    assign take      = done && !i_req_empty;
    assign o_req_pop = take;

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            state          <= IS_IDLE;
            o_app_en       <= 1'b0;
            o_app_wdf_wren <= 1'b0;
        end else begin
            if (take) begin
                o_app_en       <= 1'b1;
                o_app_wdf_wren <= ent_wr;
                state          <= ent_wr ? IS_CMD_WDATA : IS_CMD;
            end else if (done) begin
                o_app_en       <= 1'b0;
                o_app_wdf_wren <= 1'b0;
                state          <= IS_IDLE;
            end else if (state == IS_CMD_WDATA) begin
                // one channel went through, wait on the other
                if (i_app_rdy) begin
                    o_app_en <= 1'b0;
                    state    <= IS_WDATA;
                end else if (i_app_wdf_rdy) begin
                    o_app_wdf_wren <= 1'b0;
                    state          <= IS_CMD;
                end
            end
        end
    end

    // command payload
    always_ff @(posedge clk) begin
        if (take) begin
            o_app_cmd  <= ent_wr ? CMD_WRITE : CMD_READ;
            o_app_addr <= line_addr;
            // word goes to every lane, the mask picks one
            o_app_wdf_data <= {4{ent_data}};
            if (ent_wr) begin
                o_app_wdf_mask <= line_mask;
            end else begin
                o_app_wdf_mask <= {APP_MASK_W{1'b1}};
            end
        end
    end

    // single-beat bursts, end follows wren
    assign o_app_wdf_end = o_app_wdf_wren;

endmodule

// File: hw/dram_user_port.sv
/*
 * DRAM user port top level.
 * Request front end, request and read-return queues, command issuer.
 */

`timescale 1ns/1ps

module dram_user_port import dram_pkg::*; #(
    parameter int QUEUE_DEPTH_LOG2 = dram_pkg::QUEUE_DEPTH_LOG2
) (
    input  logic                   clk,
    input  logic                   rst_x_async,
    // host
    input  logic                   i_rd_en,
    input  logic                   i_wr_en,
    input  logic [USER_ADDR_W-1:0] i_addr,
    input  logic [USER_DATA_W-1:0] i_data,
    input  logic [USER_MASK_W-1:0] i_mask,
    output logic                   o_busy,
    output logic                   o_init_calib_complete,
    output logic [APP_DATA_W-1:0]  o_data,
    // controller application interface
    input  logic                   i_init_calib_complete,
    input  logic                   i_app_rdy,
    input  logic                   i_app_wdf_rdy,
    input  logic [APP_DATA_W-1:0]  i_app_rd_data,
    input  logic                   i_app_rd_data_valid,
    output logic                   o_app_en,
    output app_cmd_e               o_app_cmd,
    output logic [APP_ADDR_W-1:0]  o_app_addr,
    output logic [APP_DATA_W-1:0]  o_app_wdf_data,
    output logic                   o_app_wdf_wren,
    output logic                   o_app_wdf_end,
    output logic [APP_MASK_W-1:0]  o_app_wdf_mask
);

    logic                   req_push;
    logic [REQ_ENTRY_W-1:0] req_entry_in;
    logic                   req_pop;
    logic [REQ_ENTRY_W-1:0] req_entry_out;
    logic                   req_empty;
    logic                   req_full;
    logic                   rd_pop;
    logic [APP_DATA_W-1:0]  rd_line;
    logic                   rd_empty;

    dram_req_frontend u_frontend (
        .clk                   (clk),
        .rst_x_async           (rst_x_async),
        .i_rd_en               (i_rd_en),
        .i_wr_en               (i_wr_en),
        .i_addr                (i_addr),
        .i_data                (i_data),
        .i_mask                (i_mask),
        .i_init_calib_complete (i_init_calib_complete),
        .i_req_full            (req_full),
        .i_rd_empty            (rd_empty),
        .i_rd_line             (rd_line),
        .o_busy                (o_busy),
        .o_init_calib_complete (o_init_calib_complete),
        .o_req_push            (req_push),
        .o_req_entry           (req_entry_in),
        .o_rd_pop              (rd_pop),
        .o_data                (o_data)
    );

    dram_req_queue #(
        .WIDTH      (REQ_ENTRY_W),
        .DEPTH_LOG2 (QUEUE_DEPTH_LOG2)
    ) u_req_queue (
        .clk         (clk),
        .rst_x_async (rst_x_async),
        .i_push      (req_push),
        .i_data      (req_entry_in),
        .i_pop       (req_pop),
        .o_data      (req_entry_out),
        .o_empty     (req_empty),
        .o_full      (req_full)
    );

    dram_app_issuer u_issuer (
        .clk            (clk),
        .rst_x_async    (rst_x_async),
        .i_req_empty    (req_empty),
        .i_req_entry    (req_entry_out),
        .i_app_rdy      (i_app_rdy),
        .i_app_wdf_rdy  (i_app_wdf_rdy),
        .o_req_pop      (req_pop),
        .o_app_en       (o_app_en),
        .o_app_cmd      (o_app_cmd),
        .o_app_addr     (o_app_addr),
        .o_app_wdf_data (o_app_wdf_data),
        .o_app_wdf_wren (o_app_wdf_wren),
        .o_app_wdf_end  (o_app_wdf_end),
        .o_app_wdf_mask (o_app_wdf_mask)
    );

    // one read outstanding at a time, never fills
    dram_req_queue #(
        .WIDTH      (APP_DATA_W),
        .DEPTH_LOG2 (QUEUE_DEPTH_LOG2)
    ) u_rd_queue (
        .clk         (clk),
        .rst_x_async (rst_x_async),
        .i_push      (i_app_rd_data_valid),
        .i_data      (i_app_rd_data),
        .i_pop       (rd_pop),
        .o_data      (rd_line),
        .o_empty     (rd_empty),
        .o_full      ()
    );

endmodule

// File: tb/app_mem_model.sv
/*
 * Behavioral application-interface memory.
 * Random ready levels, masked line writes, delayed read returns,
 * calibration done shortly after reset.
 */

`timescale 1ns/1ps

module app_mem_model import dram_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_x_async,
    input  logic                  i_hold,
    input  logic                  i_app_en,
    input  logic [2:0]            i_app_cmd,
    input  logic [APP_ADDR_W-1:0] i_app_addr,
    input  logic [APP_DATA_W-1:0] i_app_wdf_data,
    input  logic                  i_app_wdf_wren,
    input  logic [APP_MASK_W-1:0] i_app_wdf_mask,
    output logic                  o_app_rdy,
    output logic                  o_app_wdf_rdy,
    output logic [APP_DATA_W-1:0] o_app_rd_data,
    output logic                  o_app_rd_data_valid,
    output logic                  o_init_calib_complete
);

    logic [APP_DATA_W-1:0]            mem [logic [APP_ADDR_W-1:0]];
    logic [APP_ADDR_W-1:0]            cmd_q [$];
    logic [APP_MASK_W+APP_DATA_W-1:0] wdf_q [$];
    logic [APP_DATA_W-1:0]            rd_line = '0;
    int                               rd_wait = 0;
    int                               calib_cnt = 0;

    initial begin
        o_app_rdy             = 1'b0;
        o_app_wdf_rdy         = 1'b0;
        o_app_rd_data         = '0;
        o_app_rd_data_valid   = 1'b0;
        o_init_calib_complete = 1'b0;
    end

    // command and write data pair up in order
    always @(posedge clk) begin : accept
        logic [APP_DATA_W-1:0] line;
        logic [APP_DATA_W-1:0] wd;
        logic [APP_MASK_W-1:0] wm;
        if (rd_wait > 0) begin
            rd_wait <= rd_wait - 1;
        end
        if (i_app_en && o_app_rdy) begin
            if (i_app_cmd == CMD_WRITE) begin
                cmd_q.push_back(i_app_addr);
            end else begin
                rd_line <= mem.exists(i_app_addr) ? mem[i_app_addr] : '0;
                rd_wait <= $urandom_range(6, 2);
            end
        end
        if (i_app_wdf_wren && o_app_wdf_rdy) begin
            wdf_q.push_back({i_app_wdf_mask, i_app_wdf_data});
        end
        if (cmd_q.size() > 0 && wdf_q.size() > 0) begin
            line = mem.exists(cmd_q[0]) ? mem[cmd_q[0]] : '0;
            {wm, wd} = wdf_q.pop_front();
            // mask bit set keeps the stored byte
            for (int b = 0; b < APP_MASK_W; b++) begin
                if (!wm[b]) begin
                    line[b*8 +: 8] = wd[b*8 +: 8];
                end
            end
            mem[cmd_q.pop_front()] = line;
        end
    end

    always @(negedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            o_app_rdy             <= 1'b0;
            o_app_wdf_rdy         <= 1'b0;
            o_app_rd_data_valid   <= 1'b0;
            o_init_calib_complete <= 1'b0;
            calib_cnt             <= 0;
        end else begin
            // each ready high about three cycles in four
            o_app_rdy           <= !i_hold && ($urandom_range(3, 0) != 0);
            o_app_wdf_rdy       <= !i_hold && ($urandom_range(3, 0) != 0);
            o_app_rd_data_valid <= (rd_wait == 1);
            o_app_rd_data       <= rd_line;
            if (calib_cnt == 10) begin
                o_init_calib_complete <= 1'b1;
            end else begin
                calib_cnt <= calib_cnt + 1;
            end
        end
    end

endmodule

// File: tb/tb_dram_user_port.sv
/*
 * Testbench for the DRAM user port.
 * Host request tasks, shadow memory and reference line function,
 * read compare and command check processes, back-pressure and random tests, timeout.
 */

`timescale 1ns/1ps

module tb_dram_user_port
    import dram_pkg::*;
();

    localparam int RAND_OPS = 200;
    // directed tests plus about 30 cycles per random op, with margin
    localparam int MAX_CYCLES = 20000;
    // issuer holds one write, the queue holds the rest
    localparam int FILL_WRITES = (1 << QUEUE_DEPTH_LOG2) + 1;

    logic                  clk;
    logic                  rst_x_async;
    logic                  i_rd_en;
    logic                  i_wr_en;
    logic [31:0]           i_addr;
    logic [31:0]           i_data;
    logic [3:0]            i_mask;
    logic                  o_busy;
    logic                  o_init_calib_complete;
    logic [APP_DATA_W-1:0] o_data;
    logic                  i_init_calib_complete;
    logic                  i_app_rdy;
    logic                  i_app_wdf_rdy;
    logic [APP_DATA_W-1:0] i_app_rd_data;
    logic                  i_app_rd_data_valid;
    logic                  o_app_en;
    app_cmd_e              o_app_cmd;
    logic [APP_ADDR_W-1:0] o_app_addr;
    logic [APP_DATA_W-1:0] o_app_wdf_data;
    logic                  o_app_wdf_wren;
    logic                  o_app_wdf_end;
    logic [APP_MASK_W-1:0] o_app_wdf_mask;
    logic                  hold_fixed = 1'b0;
    logic                  stress = 1'b0;
    logic [31:0]           shadow [logic [25:0]];
    // {write flag, address} of each host request, in issue order
    logic [32:0]           req_q [$];
    logic [31:0]           rd_addr = '0;
    logic                  rd_check = 1'b0;
    logic                  busy_q = 1'b1;
    int                    errors = 0;
    int                    checks = 0;
    int                    cycles = 0;
    string                 test_name = "reset_calib";

    dram_user_port #(.QUEUE_DEPTH_LOG2(QUEUE_DEPTH_LOG2)) DUT (.*);

    app_mem_model u_mem (
        .clk                   (clk),
        .rst_x_async           (rst_x_async),
        // stress phase holds both readies low 6 cycles in 16
        .i_hold                (hold_fixed || (stress && ((cycles % 16) < 6))),
        .i_app_en              (o_app_en),
        .i_app_cmd             (o_app_cmd),
        .i_app_addr            (o_app_addr),
        .i_app_wdf_data        (o_app_wdf_data),
        .i_app_wdf_wren        (o_app_wdf_wren),
        .i_app_wdf_mask        (o_app_wdf_mask),
        .o_app_rdy             (i_app_rdy),
        .o_app_wdf_rdy         (i_app_wdf_rdy),
        .o_app_rd_data         (i_app_rd_data),
        .o_app_rd_data_valid   (i_app_rd_data_valid),
        .o_init_calib_complete (i_init_calib_complete)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic void shadow_write(input logic [31:0] a, input logic [31:0] d,
                                         input logic [3:0] m);
        if (!shadow.exists(a[27:2])) begin
            shadow[a[27:2]] = '0;
        end
        for (int b = 0; b < 4; b++) begin
            if (!m[b]) begin
                shadow[a[27:2]][b*8 +: 8] = d[b*8 +: 8];
            end
        end
    endfunction

    // four shadow words of the 16-byte line, lane 0 lowest
    function automatic logic [APP_DATA_W-1:0] ref_line(input logic [31:0] a);
        logic [APP_DATA_W-1:0] line;
        logic [25:0]           key;
        line = '0;
        for (int l = 0; l < 4; l++) begin
            key = {a[27:4], l[1:0]};
            if (shadow.exists(key)) begin
                line[l*32 +: 32] = shadow[key];
            end
        end
        return line;
    endfunction

    task automatic strobe(input logic wr, input logic [31:0] a, input logic [31:0] d,
                          input logic [3:0] m);
        while (o_busy) @(negedge clk);
        i_wr_en = wr;
        i_rd_en = !wr;
        i_addr  = a;
        i_data  = d;
        i_mask  = m;
        @(negedge clk);
        i_wr_en = 1'b0;
        i_rd_en = 1'b0;
        req_q.push_back({wr, a});
        if (wr) begin
            shadow_write(a, d, m);
        end else begin
            rd_addr  = a;
            rd_check = 1'b1;
        end
    endtask

    task automatic host_access(input logic wr, input logic [31:0] a, input logic [31:0] d,
                               input logic [3:0] m);
        strobe(wr, a, d, m);
        while (o_busy) @(negedge clk);
    endtask

    // read result is checked where o_busy falls
    always @(negedge clk) begin : compare
        logic [APP_DATA_W-1:0] exp_line;
        if (rd_check && busy_q && !o_busy) begin
            exp_line = ref_line(rd_addr);
            checks++;
            if (o_data !== exp_line) begin
                errors++;
                $display("ERR %s: addr %h expected %h actual %h",
                         test_name, rd_addr, exp_line, o_data);
            end
            rd_check = 1'b0;
        end
        busy_q = o_busy;
    end

    // accepted commands follow the host requests in order
    always @(posedge clk) begin : cmd_check
        logic [32:0]           req;
        logic [APP_ADDR_W-1:0] exp_addr;
        app_cmd_e              exp_cmd;
        if (o_app_wdf_end !== o_app_wdf_wren) begin
            errors++;
            $display("ERR %s: expected wdf_end %b actual %b",
                     test_name, o_app_wdf_wren, o_app_wdf_end);
        end
        if (o_app_en === 1'b1 && i_app_rdy === 1'b1) begin
            if (req_q.size() == 0) begin
                errors++;
                $display("command accepted with no host request pending");
            end else begin
                req = req_q.pop_front();
                // line address from bit 3 up, low bits zero
                exp_addr = '0;
                exp_addr[26:3] = req[27:4];
                exp_cmd = req[32] ? CMD_WRITE : CMD_READ;
                checks++;
                if (o_app_addr !== exp_addr || o_app_cmd !== exp_cmd) begin
                    errors++;
                    $display("ERR %s: expected cmd %0d addr %h actual cmd %0d addr %h",
                             test_name, exp_cmd, exp_addr, o_app_cmd, o_app_addr);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("checks: %0d  errors: %0d", checks, errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        int lat;
        void'($urandom(616));
        rst_x_async = 1'b0;
        i_rd_en = 1'b0;
        i_wr_en = 1'b0;
        i_addr = '0;
        i_data = '0;
        i_mask = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_x_async = 1'b1;

        checks += 3;
        if (o_busy !== 1'b1 || o_app_en !== 1'b0 || o_app_wdf_wren !== 1'b0) begin
            errors++;
            $display("ERR %s: expected busy/en/wren 100 actual %b%b%b",
                     test_name, o_busy, o_app_en, o_app_wdf_wren);
        end
        wait (i_init_calib_complete === 1'b1);
        lat = 0;
        while (o_init_calib_complete !== 1'b1) begin
            @(negedge clk);
            lat++;
        end
        checks++;
        if (lat != 2) begin
            errors++;
            $display("ERR %s: expected calib delay 2 actual %0d", test_name, lat);
        end
        @(negedge clk);
        checks++;
        if (o_busy !== 1'b0) begin
            errors++;
            $display("ERR %s: expected busy 0 actual %b", test_name, o_busy);
        end

        test_name = "lanes";
        for (int l = 0; l < 4; l++) begin
            host_access(1'b1, 32'h100 + l * 4, 32'hA0B0C0D0 + l * 32'h01010101, 4'h0);
        end
        host_access(1'b0, 32'h100, '0, '0);
        host_access(1'b0, 32'h10C, '0, '0);

        test_name = "byte_mask";
        host_access(1'b1, 32'h204, 32'h11223344, 4'h0);
        host_access(1'b1, 32'h204, 32'hAABBCCDD, 4'h5);
        host_access(1'b0, 32'h200, '0, '0);
        host_access(1'b1, 32'h208, 32'h55667788, 4'hE);
        host_access(1'b1, 32'h204, 32'hFFFFFFFF, 4'hF);
        host_access(1'b0, 32'h20C, '0, '0);

        test_name = "backpressure";
        hold_fixed = 1'b1;
        @(negedge clk);
        for (int i = 0; i < FILL_WRITES - 1; i++) begin
            host_access(1'b1, 32'h300 + i * 4, 32'hC0DE0000 + i, 4'h0);
        end
        // this one fills the request queue
        strobe(1'b1, 32'h310, 32'hC0DE00FF, 4'h0);
        repeat (8) begin
            checks++;
            if (o_busy !== 1'b1) begin
                errors++;
                $display("ERR %s: expected busy 1 actual %b", test_name, o_busy);
            end
            @(negedge clk);
        end
        hold_fixed = 1'b0;
        while (o_busy) @(negedge clk);
        stress = 1'b1;
        for (int i = 0; i < 24; i++) begin
            host_access(1'b1, 32'h300 + $urandom_range(7, 0) * 4, $urandom,
                        4'($urandom_range(15, 0)));
        end
        stress = 1'b0;
        host_access(1'b0, 32'h300, '0, '0);
        host_access(1'b0, 32'h310, '0, '0);

        test_name = "random";
        for (int i = 0; i < RAND_OPS; i++) begin
            if ($urandom_range(1, 0) == 1) begin
                host_access(1'b1, 32'h1000 + $urandom_range(63, 0) * 4, $urandom,
                            4'($urandom_range(15, 0)));
            end else begin
                host_access(1'b0, 32'h1000 + $urandom_range(63, 0) * 4, '0, '0);
            end
        end

        @(negedge clk);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: vlog.f
hw/dram_pkg.sv
hw/dram_req_queue.sv
hw/dram_req_frontend.sv
hw/dram_app_issuer.sv
hw/dram_user_port.sv
tb/app_mem_model.sv
tb/tb_dram_user_port.sv

// File: Bender.yml
package:
  name: dram_user_port

sources:
  - files:
      - hw/dram_pkg.sv
      - hw/dram_req_queue.sv
      - hw/dram_req_frontend.sv
      - hw/dram_app_issuer.sv
      - hw/dram_user_port.sv
  - target: simulation
    files:
      - tb/app_mem_model.sv
      - tb/tb_dram_user_port.sv
